/* run.sh */
#!/bin/sh
# Builds the write monitor testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_write_guard -o tb_write_guard

./obj_dir/tb_write_guard | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
exit 0

/* sim/tb_ref.svh */
/*
  Reference model, random source and compare task of the write monitor testbench.
  Included inside the testbench module after the package import.
*/

logic [31:0] lfsr_state;
int          err_count;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic int unsigned take_bits(input int unsigned n);
  int unsigned v;
  v = 0;
  for (int unsigned i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    v = (v << 1) | int'(lfsr_state[0]);
  end
  return v;
endfunction

// Expected report of one sequential write, phases checked in bus order
function automatic fault_report_t predict_fault(input int unsigned aw_wait,
                                                input int unsigned w_total,
                                                input int unsigned b_wait,
                                                input budget_t bud,
                                                input logic [7:0] len,
                                                input logic [3:0] id,
                                                input logic [31:0] addr);
  fault_report_t r;
  int unsigned   w_budget;
  w_budget = int'(bud.w_beat_budget) * (int'(len) + 1);
  r = '{cause: NONE, id: '0, addr: '0};
  if (aw_wait > int'(bud.aw_budget)) begin
    r = '{cause: AW_TIMEOUT, id: id, addr: addr};
  end else if (w_total > w_budget) begin
    r = '{cause: W_TIMEOUT, id: id, addr: addr};
  end else if (b_wait > int'(bud.b_budget)) begin
    r = '{cause: B_TIMEOUT, id: id, addr: addr};
  end
  return r;
endfunction

task automatic compare_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
  if (got !== exp) begin
    $display("MISMATCH %s: got %h expected %h", name, got, exp);
    err_count++;
  end
endtask

/* sim/tb_write_guard.sv */
/*
  Testbench of the AXI write monitor with one write on the bus at a time.
  Budgets and delays come from an LFSR and keep a margin around each budget edge.
*/
module tb_write_guard;
  import wg_pkg::*;

  `include "tb_ref.svh"

  localparam int NumScen    = 20;
  localparam int ScenCycles = 80;

  logic          clk_i;
  logic          rst_ni;
  logic          wr_en_i;
  aw_mon_t       aw_i;
  w_mon_t        w_i;
  b_mon_t        b_i;
  budget_t       budget_i;
  logic          reset_clear_i;
  logic          irq_o;
  logic          reset_req_o;
  fault_report_t report_o;

  int            cyc = 0;
  logic          check_req;
  fault_report_t exp_report;
  int            win_start;
  int            win_bud;
  int            irq_cnt;
  int            rise_cyc;
  logic          prev_req;

  write_guard i_dut (
    .clk_i, .rst_ni, .wr_en_i, .aw_i, .w_i, .b_i, .budget_i, .reset_clear_i,
    .irq_o, .reset_req_o, .report_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  // Hands the expectation to the checker, then clears the latched fault
  task automatic request_check(input fault_report_t exp, input int start, input int bud);
    exp_report = exp;
    win_start  = start;
    win_bud    = bud;
    check_req  = 1'b1;
    wait (check_req == 1'b0);
    step();
    reset_clear_i = 1'b1;
    step();
    reset_clear_i = 1'b0;
    step();
    compare_value("reset_req_o after clear", 64'(reset_req_o), 64'(0));
    compare_value("report_o after clear", 64'(report_o), 64'(0));
  endtask

  task automatic run_write(input logic [3:0] id, input logic [31:0] addr,
                           input logic [7:0] len, input int d, input int g,
                           input int bd, input budget_t bud);
    fault_report_t exp;
    int            aw_start;
    int            w_start;
    int            b_start;
    exp = predict_fault(d, (int'(len) + 1) * (g + 1), bd, bud, len, id, addr);
    budget_i = bud;
    wr_en_i  = 1'b1;
    aw_i     = '{aw_valid: 1'b1, aw_ready: (d == 0), id: id, addr: addr, len: len};
    aw_start = cyc;
    step();
    wr_en_i = 1'b0;
    for (int k = 1; k <= d; k++) begin
      aw_i.aw_ready = (k == d);
      step();
    end
    aw_i    = '0;
    w_start = cyc;
    for (int b = 0; b <= int'(len); b++) begin
      for (int j = 0; j <= g; j++) begin
        w_i = '{w_valid: 1'b1, w_ready: (j == g), w_last: (b == int'(len))};
        step();
      end
    end
    w_i     = '0;
    b_start = cyc;
    for (int j = 0; j <= bd; j++) begin
      b_i = '{b_valid: 1'b1, b_ready: (j == bd), id: id};
      step();
    end
    b_i = '0;
    repeat (4) step();
    case (exp.cause)
      AW_TIMEOUT: request_check(exp, aw_start, int'(bud.aw_budget));
      W_TIMEOUT:  request_check(exp, w_start, int'(bud.w_beat_budget) * (int'(len) + 1));
      B_TIMEOUT:  request_check(exp, b_start, int'(bud.b_budget));
      default:    request_check(exp, 0, 0);
    endcase
  endtask

  // Two writes of ID 5 and one of ID 9 with the B for ID 9 returning first
  task automatic run_interleaved();
    logic [3:0] ids [3];
    ids = '{4'h5, 4'h5, 4'h9};
    budget_i = '{aw_budget: 12'd8, w_beat_budget: 12'd20, b_budget: 12'd60};
    for (int t = 0; t < 3; t++) begin
      wr_en_i = 1'b1;
      aw_i    = '{aw_valid: 1'b1, aw_ready: 1'b1, id: ids[t], addr: 32'h1000 * (t + 1),
                  len: 8'd1};
      step();
    end
    wr_en_i = 1'b0;
    aw_i    = '0;
    for (int t = 0; t < 6; t++) begin
      w_i = '{w_valid: 1'b1, w_ready: 1'b1, w_last: (t % 2 == 1)};
      step();
    end
    w_i = '0;
    for (int t = 2; t >= 0; t--) begin
      b_i = '{b_valid: 1'b1, b_ready: 1'b1, id: ids[t]};
      step();
    end
    b_i = '0;
    repeat (4) step();
    request_check(predict_fault(0, 2, 0, budget_i, 8'd1, 4'h5, 32'h1000), 0, 0);
  endtask

  task automatic run_unwanted_b(input logic [3:0] id);
    int start;
    start = cyc;
    b_i   = '{b_valid: 1'b1, b_ready: 1'b1, id: id};
    step();
    b_i = '0;
    repeat (4) step();
    request_check(fault_report_t'{cause: UNWANTED_B, id: id, addr: '0}, start, 0);
  endtask

  // Fifth request while four writes are tracked
  task automatic run_overflow();
    logic [3:0]  id;
    logic [31:0] addr;
    int          start;
    id    = '0;
    addr  = '0;
    start = 0;
    budget_i = '{aw_budget: 12'd8, w_beat_budget: 12'd200, b_budget: 12'd8};
    for (int t = 0; t < 5; t++) begin
      id      = 4'(take_bits(4));
      addr    = 32'(take_bits(32));
      start   = cyc;
      wr_en_i = 1'b1;
      aw_i    = '{aw_valid: 1'b1, aw_ready: 1'b1, id: id, addr: addr, len: 8'd0};
      step();
    end
    wr_en_i = 1'b0;
    aw_i    = '0;
    repeat (4) step();
    request_check(fault_report_t'{cause: OVERFLOW, id: id, addr: addr}, start, 0);
  endtask

  // Checker samples on the falling edge where outputs are settled
  initial begin
    irq_cnt  = 0;
    rise_cyc = -1;
    prev_req = 1'b0;
    forever begin
      @(negedge clk_i);
      if (irq_o === 1'b1) begin
        irq_cnt++;
      end
      if (reset_req_o === 1'b1 && !prev_req && rise_cyc < 0) begin
        rise_cyc = cyc;
      end
      prev_req = (reset_req_o === 1'b1);
      if (check_req) begin
        compare_value("irq_o pulses", 64'(irq_cnt), 64'((exp_report.cause == NONE) ? 0 : 1));
        compare_value("reset_req_o", 64'(reset_req_o), 64'(exp_report.cause != NONE));
        compare_value("report_o.cause", 64'(report_o.cause), 64'(exp_report.cause));
        compare_value("report_o.id", 64'(report_o.id), 64'(exp_report.id));
        compare_value("report_o.addr", 64'(report_o.addr), 64'(exp_report.addr));
        if (exp_report.cause != NONE) begin
          if (rise_cyc < 0) begin
            $display("Expected fault %s was never raised", exp_report.cause.name());
            err_count++;
          end else if (rise_cyc - win_start < win_bud + 1 ||
                       rise_cyc - win_start > win_bud + 3) begin
            $display("Fault %s raised %0d cycles after phase start, allowed %0d to %0d",
                     exp_report.cause.name(), rise_cyc - win_start, win_bud + 1, win_bud + 3);
            err_count++;
          end
        end
        irq_cnt   = 0;
        rise_cyc  = -1;
        check_req = 1'b0;
      end
    end
  end

  initial begin
    repeat (NumScen * ScenCycles + 20) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    budget_t     bud;
    logic [3:0]  id;
    logic [31:0] addr;
    logic [7:0]  len;
    int          kind;
    int          d;
    int          g;
    int          bd;
    lfsr_state    = 32'hc7a6;
    err_count     = 0;
    check_req     = 1'b0;
    rst_ni        = 1'b0;
    wr_en_i       = 1'b0;
    aw_i          = '0;
    w_i           = '0;
    b_i           = '0;
    budget_i      = '0;
    reset_clear_i = 1'b0;
    repeat (10) step();
    rst_ni = 1'b1;
    step();

    run_interleaved();
    for (int n = 0; n < 12; n++) begin
      kind = n % 4;
      id   = 4'(take_bits(4));
      addr = 32'(take_bits(32));
      len  = 8'(take_bits(2));
      bud.aw_budget     = 12'(2 + take_bits(3));
      bud.w_beat_budget = 12'(2 + take_bits(2));
      bud.b_budget      = 12'(2 + take_bits(3));
      d  = int'(take_bits(4)) % (int'(bud.aw_budget) + 1);
      g  = int'(take_bits(2)) % int'(bud.w_beat_budget);
      bd = int'(take_bits(4)) % (int'(bud.b_budget) + 1);
      if (kind == 1) begin
        d = int'(bud.aw_budget) + 3 + int'(take_bits(2));
      end else if (kind == 2) begin
        g = int'(bud.w_beat_budget) + 1 + int'(take_bits(1));
      end else if (kind == 3) begin
        bd = int'(bud.b_budget) + 2 + int'(take_bits(2));
      end
      run_write(id, addr, len, d, g, bd, bud);
      if (kind == 2) begin
        // Same burst with a per-beat budget that covers it
        bud.w_beat_budget = 12'(g + 1);
        run_write(id, addr, len, d, g, bd, bud);
      end
    end
    run_unwanted_b(4'hb);
    run_overflow();
    bud = '{aw_budget: 12'd4, w_beat_budget: 12'd3, b_budget: 12'd4};
    run_write(4'h3, 32'hbeef_0040, 8'd2, 1, 1, 2, bud);

    $display("Checks done, %0d errors", err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src/wg_id_table.sv */
/*
  Slot pool with per-ID queues kept as a head-tail table and next pointers.
  The table has one entry per slot, so a free entry always exists while a slot is free.
  A retired slot is not reused in the same cycle.
*/
module wg_id_table (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              wr_en_i,
  input  wg_pkg::aw_mon_t   aw_i,
  input  wg_pkg::b_mon_t    b_i,
  input  logic              flush_i,
  input  logic              retire_i,
  input  wg_pkg::slot_idx_t retire_slot_i,
  output logic              alloc_valid_o,
  output wg_pkg::slot_idx_t alloc_slot_o,
  output logic              b_hit_o,
  output wg_pkg::slot_idx_t b_slot_o,
  output logic              b_miss_o,
  output logic              overflow_o
);
  import wg_pkg::*;

  typedef struct packed {
    logic               live;
    logic [IdWidth-1:0] id;
    slot_idx_t          head;
    slot_idx_t          tail;
  } ht_entry_t;

  ht_entry_t          ht_q   [MaxTxns];
  ht_entry_t          ht_d   [MaxTxns];
  slot_idx_t          next_q [MaxTxns];
  slot_idx_t          next_d [MaxTxns];
  logic [MaxTxns-1:0] free_q;
  logic [MaxTxns-1:0] free_d;
  logic [MaxTxns-1:0] b_match;
  logic [MaxTxns-1:0] retire_match;
  logic [MaxTxns-1:0] alloc_in_queue;

  assign alloc_valid_o = wr_en_i && (|free_q);
  assign overflow_o    = wr_en_i && !(|free_q);
  assign b_hit_o       = |b_match;
  assign b_miss_o      = b_i.b_valid && b_i.b_ready && !(|b_match);

  // Lowest free slot wins
  always_comb begin
    alloc_slot_o = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_slot_o = slot_idx_t'(i);
      end
    end
  end

  // Live IDs are unique, so at most one entry matches
  always_comb begin
    b_slot_o = '0;
    for (int e = 0; e < MaxTxns; e++) begin
      b_match[e]        = ht_q[e].live && (ht_q[e].id == b_i.id);
      retire_match[e]   = ht_q[e].live && (ht_q[e].head == retire_slot_i);
      alloc_in_queue[e] = ht_q[e].live &&
                          ((ht_q[e].head == alloc_slot_o) || (ht_q[e].tail == alloc_slot_o));
      if (b_match[e]) begin
        b_slot_o = ht_q[e].head;
      end
    end
  end

  always_comb begin
    logic appended;
    logic placed;
    free_d   = free_q;
    ht_d     = ht_q;
    next_d   = next_q;
    appended = 1'b0;
    placed   = 1'b0;

    // Pop first, so a request for the same ID sees the updated queue
    if (retire_i) begin
      free_d[retire_slot_i] = 1'b1;
      for (int e = 0; e < MaxTxns; e++) begin
        if (retire_match[e]) begin
          if (ht_q[e].head == ht_q[e].tail) begin
            ht_d[e].live = 1'b0;
          end else begin
            ht_d[e].head = next_q[ht_q[e].head];
          end
        end
      end
    end

    if (alloc_valid_o) begin
      free_d[alloc_slot_o] = 1'b0;
      // Append behind the tail of an existing queue
      for (int e = 0; e < MaxTxns; e++) begin
        if (!appended && ht_d[e].live && (ht_d[e].id == aw_i.id)) begin
          next_d[ht_d[e].tail] = alloc_slot_o;
          ht_d[e].tail         = alloc_slot_o;
          appended             = 1'b1;
        end
      end
      // Otherwise open a new queue in the first idle entry
      for (int e = 0; e < MaxTxns; e++) begin
        if (!appended && !placed && !ht_d[e].live) begin
          ht_d[e] = '{live: 1'b1, id: aw_i.id, head: alloc_slot_o, tail: alloc_slot_o};
          placed  = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      free_q <= '1;
      for (int e = 0; e < MaxTxns; e++) begin
        ht_q[e] <= '0;
      end
    end else if (flush_i) begin
      free_q <= '1;
      for (int e = 0; e < MaxTxns; e++) begin
        ht_q[e].live <= 1'b0;
      end
    end else begin
      free_q <= free_d;
      ht_q   <= ht_d;
    end
  end

  always_ff @(posedge clk_i) begin
    next_q <= next_d;
  end

  // A slot taken from the free mask is not still linked into any queue
  a_alloc_was_free : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_valid_o |-> free_q[alloc_slot_o] && !(|alloc_in_queue));

  // The slot FSMs only retire the oldest write of an ID
  a_retire_is_head : assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_i |-> |retire_match);

endmodule

/* src/wg_order_fifo.sv */
/*
  Order in which slots own the W channel, one entry per AW request.
  Depth is MaxTxns and must be a power of two.
*/
module wg_order_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              push_i,
  input  wg_pkg::slot_idx_t push_slot_i,
  input  logic              pop_i,
  input  logic              flush_i,
  output wg_pkg::slot_idx_t head_o,
  output logic              empty_o
);
  import wg_pkg::*;

  slot_idx_t             mem_q [MaxTxns];
  slot_idx_t             wr_ptr_q;
  slot_idx_t             rd_ptr_q;
  logic [SlotIdxWidth:0] count_q;
  logic                  full;

  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full    = (count_q == (SlotIdxWidth + 1)'(MaxTxns));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_slot_i;
    end
  end

  // Pool and FIFO have the same depth, so a granted slot always finds room
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i && !flush_i |-> !full);

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

/* src/wg_pkg.sv */
/*
  Shared sizes and types of the AXI write monitor.
  MaxTxns must equal 2**SlotIdxWidth, because the slot and FIFO pointers wrap freely.
  Budgets are CntWidth wide and should stay below the all-ones value.
*/
package wg_pkg;

  localparam int unsigned MaxTxns      = 4;
  localparam int unsigned IdWidth      = 4;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned LenWidth     = 8;
  localparam int unsigned CntWidth     = 12;
  localparam int unsigned SlotIdxWidth = 2;

  typedef logic [SlotIdxWidth-1:0] slot_idx_t;

  // Observed AW channel, sampled without back-pressure
  typedef struct packed {
    logic                 aw_valid;
    logic                 aw_ready;
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } aw_mon_t;

  typedef struct packed {
    logic w_valid;
    logic w_ready;
    logic w_last;
  } w_mon_t;

  typedef struct packed {
    logic               b_valid;
    logic               b_ready;
    logic [IdWidth-1:0] id;
  } b_mon_t;

  // The W budget is given per beat and scaled by the burst length
  typedef struct packed {
    logic [CntWidth-1:0] aw_budget;
    logic [CntWidth-1:0] w_beat_budget;
    logic [CntWidth-1:0] b_budget;
  } budget_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_ADDRESS,
    WRITE_DATA,
    WRITE_RESPONSE
  } phase_e;

  typedef enum logic [2:0] {
    NONE,
    AW_TIMEOUT,
    W_TIMEOUT,
    B_TIMEOUT,
    UNWANTED_B,
    OVERFLOW
  } fault_cause_e;

  typedef struct packed {
    fault_cause_e         cause;
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
  } fault_report_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
  } slot_meta_t;

endpackage

/* src/wg_txn_slots.sv */
/*
  Per-slot phase FSMs with one counter each.
  Only one AW request is pending on the bus at a time, so an AW handshake moves every
  slot in WRITE_ADDRESS. Counters do not saturate, so budgets must stay below all ones.
*/
module wg_txn_slots (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  wg_pkg::budget_t      budget_i,
  input  wg_pkg::aw_mon_t      aw_i,
  input  wg_pkg::w_mon_t       w_i,
  input  wg_pkg::b_mon_t       b_i,
  input  logic                 alloc_valid_i,
  input  wg_pkg::slot_idx_t    alloc_slot_i,
  input  logic                 flush_i,
  input  wg_pkg::slot_idx_t    w_head_i,
  input  logic                 w_empty_i,
  input  logic                 b_hit_i,
  input  wg_pkg::slot_idx_t    b_slot_i,
  output logic                 w_pop_o,
  output logic                 retire_o,
  output wg_pkg::slot_idx_t    retire_slot_o,
  output logic                 b_early_o,
  output logic                 timeout_o,
  output wg_pkg::fault_cause_e timeout_cause_o,
  output wg_pkg::slot_meta_t   timeout_meta_o
);
  import wg_pkg::*;

  phase_e                     phase_q    [MaxTxns];
  phase_e                     phase_d    [MaxTxns];
  logic [CntWidth-1:0]        cnt_q      [MaxTxns];
  logic [CntWidth-1:0]        cnt_d      [MaxTxns];
  logic [CntWidth-1:0]        w_bud_q    [MaxTxns];
  slot_meta_t                 meta_q     [MaxTxns];
  fault_cause_e               slot_cause [MaxTxns];
  logic [MaxTxns-1:0]         slot_to;
  logic [CntWidth+LenWidth:0] w_prod;
  logic [CntWidth-1:0]        w_bud_new;
  logic                       aw_hs;
  logic                       w_last_hs;
  logic                       b_hs;

  assign aw_hs     = aw_i.aw_valid && aw_i.aw_ready;
  assign w_last_hs = w_i.w_valid && w_i.w_ready && w_i.w_last;
  assign b_hs      = b_i.b_valid && b_i.b_ready && b_hit_i;

  // W budget scales with the beat count and saturates
  assign w_prod    = budget_i.w_beat_budget * (aw_i.len + 1'b1);
  assign w_bud_new = (|w_prod[CntWidth+LenWidth:CntWidth]) ? '1 : w_prod[CntWidth-1:0];

  assign w_pop_o       = w_last_hs && (phase_q[w_head_i] == WRITE_DATA);
  assign retire_o      = b_hs && (phase_q[b_slot_i] == WRITE_RESPONSE);
  assign retire_slot_o = b_slot_i;
  // B for a known ID whose oldest write has not finished its data
  assign b_early_o     = b_hs && (phase_q[b_slot_i] != WRITE_RESPONSE);

  always_comb begin
    for (int i = 0; i < MaxTxns; i++) begin
      phase_d[i]    = phase_q[i];
      cnt_d[i]      = cnt_q[i] + 1'b1;
      slot_to[i]    = 1'b0;
      slot_cause[i] = NONE;
      case (phase_q[i])
        WRITE_ADDRESS: begin
          slot_to[i]    = cnt_q[i] > budget_i.aw_budget;
          slot_cause[i] = AW_TIMEOUT;
          if (aw_hs) begin
            phase_d[i] = WRITE_DATA;
            cnt_d[i]   = '0;
          end
        end
        WRITE_DATA: begin
          slot_to[i]    = cnt_q[i] > w_bud_q[i];
          slot_cause[i] = W_TIMEOUT;
          if (w_empty_i || (w_head_i != slot_idx_t'(i))) begin
            // Waits until the older bursts are done
            cnt_d[i] = cnt_q[i];
          end else if (w_pop_o) begin
            phase_d[i] = WRITE_RESPONSE;
            cnt_d[i]   = '0;
          end
        end
        WRITE_RESPONSE: begin
          slot_to[i]    = cnt_q[i] > budget_i.b_budget;
          slot_cause[i] = B_TIMEOUT;
          if (retire_o && (b_slot_i == slot_idx_t'(i))) begin
            phase_d[i] = IDLE;
          end
        end
        default: cnt_d[i] = cnt_q[i];
      endcase
      // AW may complete in the strobe cycle itself
      if (alloc_valid_i && (alloc_slot_i == slot_idx_t'(i))) begin
        phase_d[i] = aw_hs ? WRITE_DATA : WRITE_ADDRESS;
        cnt_d[i]   = '0;
      end
    end
  end

  // Lowest slot index wins
  always_comb begin
    timeout_o       = 1'b0;
    timeout_cause_o = NONE;
    timeout_meta_o  = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (slot_to[i]) begin
        timeout_o       = 1'b1;
        timeout_cause_o = slot_cause[i];
        timeout_meta_o  = meta_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MaxTxns; i++) begin
        phase_q[i] <= IDLE;
      end
    end else if (flush_i) begin
      for (int i = 0; i < MaxTxns; i++) begin
        phase_q[i] <= IDLE;
      end
    end else begin
      phase_q <= phase_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cnt_q <= cnt_d;
    if (alloc_valid_i) begin
      w_bud_q[alloc_slot_i] <= w_bud_new;
      meta_q[alloc_slot_i]  <= '{id: aw_i.id, addr: aw_i.addr};
    end
  end

  // A slot in WRITE_DATA is always queued in the order FIFO
  a_pop_not_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_pop_o |-> !w_empty_i);

endmodule

/* src/write_guard.sv */
/*
  Passive AXI write monitor, it never drives the bus.
  The first fault latches the report and holds reset_req_o until reset_clear_i.
  Every fault flushes all tracked writes.
*/
module write_guard (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wr_en_i,
  input  wg_pkg::aw_mon_t       aw_i,
  input  wg_pkg::w_mon_t        w_i,
  input  wg_pkg::b_mon_t        b_i,
  input  wg_pkg::budget_t       budget_i,
  input  logic                  reset_clear_i,
  output logic                  irq_o,
  output logic                  reset_req_o,
  output wg_pkg::fault_report_t report_o
);
  import wg_pkg::*;

  logic          alloc_valid;
  slot_idx_t     alloc_slot;
  logic          b_hit;
  slot_idx_t     b_slot;
  logic          b_miss;
  logic          overflow;
  logic          retire;
  slot_idx_t     retire_slot;
  slot_idx_t     w_head;
  logic          w_empty;
  logic          w_pop;
  logic          b_early;
  logic          timeout;
  fault_cause_e  timeout_cause;
  slot_meta_t    timeout_meta;
  logic          flush;
  fault_report_t fault;
  logic          irq_q;
  logic          reset_req_q;
  fault_report_t report_q;

  wg_id_table i_id_table (
    .clk_i, .rst_ni, .wr_en_i, .aw_i, .b_i,
    .flush_i       (flush),
    .retire_i      (retire),
    .retire_slot_i (retire_slot),
    .alloc_valid_o (alloc_valid),
    .alloc_slot_o  (alloc_slot),
    .b_hit_o       (b_hit),
    .b_slot_o      (b_slot),
    .b_miss_o      (b_miss),
    .overflow_o    (overflow)
  );

  wg_order_fifo i_order_fifo (
    .clk_i, .rst_ni,
    .push_i      (alloc_valid),
    .push_slot_i (alloc_slot),
    .pop_i       (w_pop),
    .flush_i     (flush),
    .head_o      (w_head),
    .empty_o     (w_empty)
  );

  wg_txn_slots i_txn_slots (
    .clk_i, .rst_ni, .budget_i, .aw_i, .w_i, .b_i,
    .alloc_valid_i   (alloc_valid),
    .alloc_slot_i    (alloc_slot),
    .flush_i         (flush),
    .w_head_i        (w_head),
    .w_empty_i       (w_empty),
    .b_hit_i         (b_hit),
    .b_slot_i        (b_slot),
    .w_pop_o         (w_pop),
    .retire_o        (retire),
    .retire_slot_o   (retire_slot),
    .b_early_o       (b_early),
    .timeout_o       (timeout),
    .timeout_cause_o (timeout_cause),
    .timeout_meta_o  (timeout_meta)
  );

  // Timeouts first, then unwanted B, then overflow
  always_comb begin
    fault = '{cause: NONE, default: '0};
    if (timeout) begin
      fault = '{cause: timeout_cause, id: timeout_meta.id, addr: timeout_meta.addr};
    end else if (b_miss || b_early) begin
      fault = '{cause: UNWANTED_B, id: b_i.id, addr: '0};
    end else if (overflow) begin
      fault = '{cause: OVERFLOW, id: aw_i.id, addr: aw_i.addr};
    end
  end

  assign flush = (fault.cause != NONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q       <= 1'b0;
      reset_req_q <= 1'b0;
      report_q    <= '{cause: NONE, default: '0};
    end else begin
      irq_q <= flush && !reset_req_q;
      // Only the first fault is kept
      if (flush && !reset_req_q) begin
        reset_req_q <= 1'b1;
        report_q    <= fault;
      end else if (reset_clear_i) begin
        reset_req_q <= 1'b0;
        report_q    <= '{cause: NONE, default: '0};
      end
    end
  end

  assign irq_o       = irq_q;
  assign reset_req_o = reset_req_q;
  assign report_o    = report_q;

endmodule

/* vlog.f */
+incdir+sim
src/wg_pkg.sv
src/wg_id_table.sv
src/wg_order_fifo.sv
src/wg_txn_slots.sv
src/write_guard.sv
sim/tb_write_guard.sv
